/* flist.f */
+incdir+common
common/csr_pkg.sv
source/trap_sequencer.sv
csr/csr_machine_regs.sv
csr/csr_perf_counters.sv
source/csr_subsys_top.sv
verif/tb_csr_subsys.sv

/* Bender.yml */
package:
  name: csr_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/csr_pkg.sv
      - source/trap_sequencer.sv
      - csr/csr_machine_regs.sv
      - csr/csr_perf_counters.sv
      - source/csr_subsys_top.sv
      - target: test
        files:
          - verif/tb_csr_subsys.sv

/* verif/tb_csr_subsys.sv */
`include "csr_defs.svh"

module tb_csr_subsys;

  localparam int WATCHDOG_CYCLES = 2000;  // tests take about 350 cycles plus margin
  localparam int R_MEPC     = 0;          // model register slots
  localparam int R_MSTATUS  = 1;
  localparam int R_MESTATUS = 2;
  localparam int R_MCAUSE   = 3;

  logic               clk;
  logic               rst_n;
  csr_pkg::csr_req_t  csr_req;
  logic [31:0]        csr_rdata;
  logic [3:0]         core_id;
  logic [5:0]         cluster_id;
  csr_pkg::pc_set_t   pcs;
  csr_pkg::perf_evt_t evt;
  logic               exc_req;
  logic [5:0]         exc_cause;
  csr_pkg::pc_src_e   exc_pc_src;
  logic               mret;
  logic               irq_enable;
  logic [31:0]        mepc;
  logic               trap_active;

  int tests_run;
  int tests_failed;
  int errors;
  int test_errors;

  // reference model with machine regs in read format
  logic [31:0] m_reg [4];
  logic [31:0] m_cnt [`CSR_N_PERF_EVT];
  logic        m_trap;

  csr_subsys_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .csr_req_i     (csr_req),
    .csr_rdata_o   (csr_rdata),
    .core_id_i     (core_id),
    .cluster_id_i  (cluster_id),
    .pcs_i         (pcs),
    .evt_i         (evt),
    .exc_req_i     (exc_req),
    .exc_cause_i   (exc_cause),
    .exc_pc_src_i  (exc_pc_src),
    .mret_i        (mret),
    .irq_enable_o  (irq_enable),
    .mepc_o        (mepc),
    .trap_active_o (trap_active)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // bus and check helpers
  //////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #2;
    csr_req = '0;  // strobes drop unless the caller raises them
    evt     = '0;
    exc_req = 1'b0;
    mret    = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                           input logic [31:0] wdata);
    next_cycle();
    csr_req.access = 1'b1;
    csr_req.addr   = addr;
    csr_req.wdata  = wdata;
    csr_req.op     = op;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    next_cycle();
    csr_req.access = 1'b1;
    csr_req.addr   = addr;
    csr_req.op     = csr_pkg::NONE;
    #8;  // sample at the falling edge
    data = csr_rdata;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    csr_read(addr, data);
    compare(name, data, exp);
  endtask

  task automatic check_counters();
    for (int i = 0; i < `CSR_N_PERF_EVT; i++)
      check_csr($sformatf("pccr%0d", i), {`CSR_PCCR_BASE_HI, 5'(i)}, m_cnt[i]);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // machine register ops where clear removes wdata bits
  function automatic logic [31:0] mreg_op(csr_pkg::csr_op_e op, logic [31:0] old,
                                          logic [31:0] w);
    case (op)
      csr_pkg::WRITE: return w;
      csr_pkg::SET:   return old | w;
      csr_pkg::CLEAR: return old & ~w;
      default:        return old;
    endcase
  endfunction

  function automatic logic [31:0] pick_pc(csr_pkg::pc_src_e src, csr_pkg::pc_set_t p);
    case (src)
      csr_pkg::PC_ID:     return p.pc_id;
      csr_pkg::PC_EX:     return p.pc_ex;
      csr_pkg::BR_TARGET: return p.branch_target;
      default:            return p.pc_if;
    endcase
  endfunction

  function automatic logic [31:0] count_up(logic [31:0] start, int n, logic sat);
    logic [31:0] v;
    v = start;
    for (int i = 0; i < n; i++)
      if (!(sat && v == 32'hFFFF_FFFF)) v = v + 32'd1;  // sticks at max when saturating
    return v;
  endfunction

  //////////////////////////////
  // trap stimulus
  //////////////////////////////
  task automatic raise_exception(input logic [5:0] cause, input csr_pkg::pc_src_e src);
    next_cycle();
    pcs        = {$urandom(), $urandom(), $urandom(), $urandom()};
    exc_req    = 1'b1;
    exc_cause  = cause;
    exc_pc_src = src;
    if (!m_trap) begin  // ignored while in the handler
      m_reg[R_MESTATUS] = m_reg[R_MSTATUS];
      m_reg[R_MSTATUS]  = 32'h0;
      m_reg[R_MEPC]     = pick_pc(src, pcs);
      m_reg[R_MCAUSE]   = {cause[5], 26'b0, cause[4:0]};
      m_trap            = 1'b1;
    end
  endtask

  task automatic mret_pulse();
    next_cycle();
    mret = 1'b1;
    if (m_trap) begin
      m_reg[R_MSTATUS] = m_reg[R_MESTATUS];
      m_trap           = 1'b0;
    end
  endtask

  task automatic check_trap_regs();
    check_csr("mepc", `CSR_ADDR_MEPC, m_reg[R_MEPC]);
    check_csr("mcause", `CSR_ADDR_MCAUSE, m_reg[R_MCAUSE]);
    check_csr("mestatus", `CSR_ADDR_MESTATUS, m_reg[R_MESTATUS]);
    check_csr("mstatus", `CSR_ADDR_MSTATUS, m_reg[R_MSTATUS]);
    compare("irq_enable_o", {31'b0, irq_enable}, m_reg[R_MSTATUS]);
    compare("mepc_o", mepc, m_reg[R_MEPC]);
    compare("trap_active_o", {31'b0, trap_active}, {31'b0, m_trap});
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_values();
    check_csr("mstatus", `CSR_ADDR_MSTATUS, 32'h0);
    check_csr("mepc", `CSR_ADDR_MEPC, 32'h0);
    check_csr("mcause", `CSR_ADDR_MCAUSE, 32'h0);
    check_csr("pcer", `CSR_ADDR_PCER, 32'h0);
    check_csr("pcmr", `CSR_ADDR_PCMR, 32'h3);
    check_csr("mhartid", `CSR_ADDR_MHARTID, (32'(cluster_id) << 5) | 32'(core_id));
    check_csr("mimpid", `CSR_ADDR_MIMPID, `CSR_MIMPID_VAL);
    check_csr("unmapped csr", 12'h123, 32'h0);
    compare("trap_active_o", {31'b0, trap_active}, 32'h0);
    compare("irq_enable_o", {31'b0, irq_enable}, 32'h0);
    check_counters();
    finish_test("reset_values");
  endtask

  task automatic write_ops_on(input string name, input logic [11:0] addr, input int r,
                              input logic [31:0] mask);
    csr_pkg::csr_op_e op;
    logic [31:0]      w;
    for (int o = 0; o < 8; o++) begin
      op = csr_pkg::csr_op_e'((o + 1) % 4);  // write, set, clear, none
      w  = $urandom();
      csr_write(addr, op, w);
      m_reg[r] = mreg_op(op, m_reg[r], w) & mask;
      check_csr(name, addr, m_reg[r]);
      compare("irq_enable_o", {31'b0, irq_enable}, m_reg[R_MSTATUS]);
      compare("mepc_o", mepc, m_reg[R_MEPC]);
    end
  endtask

  task automatic write_set_clear();
    write_ops_on("mepc", `CSR_ADDR_MEPC, R_MEPC, 32'hFFFF_FFFF);
    write_ops_on("mstatus", `CSR_ADDR_MSTATUS, R_MSTATUS, 32'h1);
    write_ops_on("mestatus", `CSR_ADDR_MESTATUS, R_MESTATUS, 32'h1);
    write_ops_on("mcause", `CSR_ADDR_MCAUSE, R_MCAUSE, 32'h8000_001F);  // irq flag + code
    finish_test("write_set_clear");
  endtask

  task automatic trap_save();
    for (int s = 0; s < 4; s++) begin
      csr_write(`CSR_ADDR_MSTATUS, csr_pkg::WRITE, 32'h1);
      m_reg[R_MSTATUS] = 32'h1;
      raise_exception(6'($urandom()), csr_pkg::pc_src_e'(s));
      check_trap_regs();
      check_csr("mestatus after save", `CSR_ADDR_MESTATUS, 32'h1);
      raise_exception(6'($urandom()), csr_pkg::pc_src_e'(3 - s));  // must be dropped
      check_trap_regs();
      mret_pulse();
    end
    finish_test("trap_save");
  endtask

  task automatic trap_return();
    csr_write(`CSR_ADDR_MSTATUS, csr_pkg::WRITE, 32'h1);
    m_reg[R_MSTATUS] = 32'h1;
    raise_exception(6'h21, csr_pkg::PC_EX);
    mret_pulse();
    check_trap_regs();
    // handler drops the saved IE before returning
    raise_exception(6'h05, csr_pkg::PC_ID);
    csr_write(`CSR_ADDR_MESTATUS, csr_pkg::WRITE, 32'h0);
    m_reg[R_MESTATUS] = 32'h0;
    mret_pulse();
    check_trap_regs();
    csr_write(`CSR_ADDR_MSTATUS, csr_pkg::WRITE, 32'h1);
    m_reg[R_MSTATUS] = 32'h1;
    mret_pulse();  // no effect in RUN
    check_trap_regs();
    finish_test("trap_return");
  endtask

  task automatic event_counting();
    logic [7:0] mask;
    logic       prev_id_valid;
    int         n_cycles;
    mask     = 8'hDF;  // load counter left off
    n_cycles = 40;
    csr_write(`CSR_ADDR_PCER, csr_pkg::WRITE, 32'h0);
    csr_write(`CSR_ADDR_PCCR_ALL, csr_pkg::WRITE, 32'h0);
    foreach (m_cnt[i]) m_cnt[i] = 32'h0;
    csr_write(`CSR_ADDR_PCMR, csr_pkg::WRITE, 32'h3);
    csr_write(`CSR_ADDR_PCER, csr_pkg::WRITE, {24'b0, mask});
    prev_id_valid = 1'b0;
    for (int c = 0; c < n_cycles; c++) begin
      next_cycle();
      evt = 9'($urandom());
      if (mask[1] && evt.id_valid && evt.is_decoding) m_cnt[1] = m_cnt[1] + 1;
      if (mask[2] && evt.ld_stall && prev_id_valid)   m_cnt[2] = m_cnt[2] + 1;
      if (mask[3] && evt.jr_stall && prev_id_valid)   m_cnt[3] = m_cnt[3] + 1;
      if (mask[4] && evt.imiss && !evt.pc_set)        m_cnt[4] = m_cnt[4] + 1;
      if (mask[5] && evt.mem_load)                    m_cnt[5] = m_cnt[5] + 1;
      if (mask[6] && evt.mem_store)                   m_cnt[6] = m_cnt[6] + 1;
      if (mask[7] && evt.branch_taken && prev_id_valid) m_cnt[7] = m_cnt[7] + 1;
      prev_id_valid = evt.id_valid;
    end
    csr_write(`CSR_ADDR_PCMR, csr_pkg::WRITE, 32'h2);  // global stop with saturate kept
    if (mask[0])
      m_cnt[0] = n_cycles + 1;  // event cycles plus the stop cycle
    next_cycle();
    next_cycle();
    check_counters();
    for (int c = 0; c < 10; c++) begin
      next_cycle();
      evt = 9'($urandom());
    end
    next_cycle();
    next_cycle();
    check_counters();  // frozen
    finish_test("event_counting");
  endtask

  task automatic preset_and_count(input logic sat, input logic [31:0] preset);
    csr_write(`CSR_ADDR_PCER, csr_pkg::WRITE, 32'h0);
    csr_write({`CSR_PCCR_BASE_HI, 5'd0}, csr_pkg::WRITE, preset);
    csr_write(`CSR_ADDR_PCMR, csr_pkg::WRITE, {30'b0, sat, 1'b1});
    csr_write(`CSR_ADDR_PCER, csr_pkg::WRITE, 32'h1);  // cycle counter only
    next_cycle();
    next_cycle();
    csr_write(`CSR_ADDR_PCMR, csr_pkg::WRITE, {30'b0, sat, 1'b0});
    next_cycle();
    next_cycle();
    m_cnt[0] = count_up(preset, 3, sat);
    check_csr(sat ? "pccr0 saturated" : "pccr0 wrapped", {`CSR_PCCR_BASE_HI, 5'd0}, m_cnt[0]);
  endtask

  task automatic counter_limits();
    logic [31:0] w;
    preset_and_count(1'b1, 32'hFFFF_FFFE);
    preset_and_count(1'b0, 32'hFFFF_FFFE);
    w = $urandom();
    csr_write(`CSR_ADDR_PCCR_ALL, csr_pkg::WRITE, w);
    foreach (m_cnt[i]) m_cnt[i] = w;
    check_counters();
    check_csr("pccr_all", `CSR_ADDR_PCCR_ALL, 32'h0);
    w = $urandom();
    csr_write({`CSR_PCCR_BASE_HI, 5'd3}, csr_pkg::SET, w);
    m_cnt[3] = m_cnt[3] | w;
    check_csr("pccr3 set", {`CSR_PCCR_BASE_HI, 5'd3}, m_cnt[3]);
    w = $urandom();
    csr_write({`CSR_PCCR_BASE_HI, 5'd3}, csr_pkg::CLEAR, w);
    m_cnt[3] = w & ~m_cnt[3];  // bank clear keeps wdata bits not set before
    check_counters();
    finish_test("counter_limits");
  endtask

  //////////////////////////////
  // run control
  //////////////////////////////
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h6e94));
    rst_n        = 1'b0;
    csr_req      = '0;
    core_id      = 4'($urandom());
    cluster_id   = 6'($urandom());
    pcs          = '0;
    evt          = '0;
    exc_req      = 1'b0;
    exc_cause    = '0;
    exc_pc_src   = csr_pkg::PC_IF;
    mret         = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    test_errors  = 0;
    m_trap       = 1'b0;
    foreach (m_reg[i]) m_reg[i] = 32'h0;
    foreach (m_cnt[i]) m_cnt[i] = 32'h0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    reset_values();
    write_set_clear();
    trap_save();
    trap_return();
    event_counting();
    counter_limits();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* source/csr_subsys_top.sv */
module csr_subsys_top (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_req_t   csr_req_i,
  output logic [31:0]         csr_rdata_o,
  input  logic [3:0]          core_id_i,
  input  logic [5:0]          cluster_id_i,
  input  csr_pkg::pc_set_t    pcs_i,
  input  csr_pkg::perf_evt_t  evt_i,
  input  logic                exc_req_i,
  input  logic [5:0]          exc_cause_i,
  input  csr_pkg::pc_src_e    exc_pc_src_i,
  input  logic                mret_i,
  output logic                irq_enable_o,
  output logic [31:0]         mepc_o,
  output logic                trap_active_o
);

  csr_pkg::trap_ctl_t trap_ctl;     // sequencer to mregs
  logic               perf_hit;
  logic [31:0]        perf_rdata;
  logic [31:0]        mregs_rdata;  // zero on unknown address

  trap_sequencer u_trap_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .exc_req_i     (exc_req_i),
    .exc_cause_i   (exc_cause_i),
    .exc_pc_src_i  (exc_pc_src_i),
    .mret_i        (mret_i),
    .trap_ctl_o    (trap_ctl),
    .trap_active_o (trap_active_o)
  );

  csr_machine_regs u_mregs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .pcs_i        (pcs_i),
    .trap_ctl_i   (trap_ctl),
    .rdata_o      (mregs_rdata),
    .irq_enable_o (irq_enable_o),
    .mepc_o       (mepc_o)
  );

  csr_perf_counters u_perf (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_req_i (csr_req_i),
    .evt_i     (evt_i),
    .hit_o     (perf_hit),
    .rdata_o   (perf_rdata)
  );

  assign csr_rdata_o = perf_hit ? perf_rdata : mregs_rdata;  // counter bank wins on its range

endmodule

/* csr/csr_perf_counters.sv */
`include "csr_defs.svh"

module csr_perf_counters (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_req_t   csr_req_i,
  input  csr_pkg::perf_evt_t  evt_i,
  output logic                hit_o,
  output logic [31:0]         rdata_o
);

  localparam int unsigned NCNT = `CSR_N_PERF_EVT;

  logic                  id_valid_q;          // qualifies the stall events
  logic [7:0]            evt_raw;
  logic [NCNT-1:0]       cnt_in, cnt_inc, cnt_inc_q;
  logic [NCNT-1:0][31:0] cnt_q, cnt_n;
  logic [NCNT-1:0]       cnt_we;              // per counter csr write
  logic [NCNT-1:0]       pcer_q, pcer_n;
  logic [1:0]            pcmr_q, pcmr_n;      // bit0 global en, bit1 saturate
  logic                  is_pcer, is_pcmr, is_pccr, pccr_all;
  logic [4:0]            pccr_idx;
  logic                  csr_we;

  // bank op, clear here is wdata & ~old
  function automatic logic [31:0] bank_op(csr_pkg::csr_op_e op, logic [31:0] wdata,
                                          logic [31:0] old);
    case (op)
      csr_pkg::WRITE: return wdata;
      csr_pkg::SET:   return wdata | old;
      csr_pkg::CLEAR: return wdata & ~old;
      default:        return old;
    endcase
  endfunction

  //////////////////////////////
  // event inputs
  //////////////////////////////
  assign evt_raw[0] = 1'b1;                                   // cycles
  assign evt_raw[1] = evt_i.id_valid & evt_i.is_decoding;     // instructions
  assign evt_raw[2] = evt_i.ld_stall & id_valid_q;
  assign evt_raw[3] = evt_i.jr_stall & id_valid_q;
  assign evt_raw[4] = evt_i.imiss & ~evt_i.pc_set;            // fetch miss, no redirect
  assign evt_raw[5] = evt_i.mem_load;
  assign evt_raw[6] = evt_i.mem_store;
  assign evt_raw[7] = evt_i.branch_taken & id_valid_q;

  assign cnt_in  = NCNT'(evt_raw);
  assign cnt_inc = cnt_in & pcer_q & {NCNT{pcmr_q[0]}};

  //////////////////////////////
  // address decode
  //////////////////////////////
  always_comb begin
    is_pcer  = 1'b0;
    is_pcmr  = 1'b0;
    is_pccr  = 1'b0;
    pccr_all = 1'b0;
    pccr_idx = '0;
    rdata_o  = '0;
    case (csr_req_i.addr)
      `CSR_ADDR_PCER: begin
        is_pcer = 1'b1;
        rdata_o = 32'(pcer_q);
      end
      `CSR_ADDR_PCMR: begin
        is_pcmr = 1'b1;
        rdata_o = 32'(pcmr_q);
      end
      `CSR_ADDR_PCCR_ALL: begin
        is_pccr  = 1'b1;
        pccr_all = 1'b1;  // reads 0
      end
      default: ;
    endcase
    if (csr_req_i.addr[11:5] == `CSR_PCCR_BASE_HI && !pccr_all) begin
      is_pccr  = 1'b1;
      pccr_idx = csr_req_i.addr[4:0];
      if (pccr_idx < NCNT)
        rdata_o = cnt_q[pccr_idx];
    end
  end

  assign hit_o  = csr_req_i.access & (is_pcer | is_pcmr | is_pccr);
  assign csr_we = hit_o & (csr_req_i.op != csr_pkg::NONE);

  // counter update, csr write replaces the increment
  always_comb begin
    for (int i = 0; i < NCNT; i++) begin
      cnt_we[i] = csr_we & is_pccr & (pccr_all | (pccr_idx == 5'(i)));
      cnt_n[i]  = cnt_q[i];
      if (cnt_inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + 32'd1;  // wraps unless saturating
      if (cnt_we[i])
        cnt_n[i] = bank_op(csr_req_i.op, csr_req_i.wdata, cnt_q[i]);
    end
  end

  always_comb begin
    pcer_n = pcer_q;
    pcmr_n = pcmr_q;
    if (csr_we && is_pcer)
      pcer_n = NCNT'(bank_op(csr_req_i.op, csr_req_i.wdata, 32'(pcer_q)));
    if (csr_we && is_pcmr)
      pcmr_n = 2'(bank_op(csr_req_i.op, csr_req_i.wdata, 32'(pcmr_q)));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      pcer_q     <= '0;
      pcmr_q     <= 2'h3;  // enabled and saturating out of reset
      cnt_inc_q  <= '0;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= evt_i.id_valid;
      pcer_q     <= pcer_n;
      pcmr_q     <= pcmr_n;
      cnt_inc_q  <= cnt_inc;  // one stage between event and count
      cnt_q      <= cnt_n;
    end
  end

  // two cycles of global disable flush the inc pipe, only csr writes move counters then
  a_cnt_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    !pcmr_q[0] && $past(!pcmr_q[0]) && !(|cnt_we) |=> $stable(cnt_q));

endmodule

/* csr/csr_machine_regs.sv */
`include "csr_defs.svh"

module csr_machine_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_req_t   csr_req_i,
  input  logic [3:0]          core_id_i,
  input  logic [5:0]          cluster_id_i,
  input  csr_pkg::pc_set_t    pcs_i,
  input  csr_pkg::trap_ctl_t  trap_ctl_i,
  output logic [31:0]         rdata_o,
  output logic                irq_enable_o,
  output logic [31:0]         mepc_o
);

  logic        mstatus_q, mstatus_n;    // IE
  logic        mestatus_q, mestatus_n;  // IE saved on trap entry
  logic [31:0] mepc_q, mepc_n;
  logic [5:0]  mcause_q, mcause_n;      // bit5 = interrupt flag
  logic [31:0] wdata_int;               // write data after op
  logic        we_int;
  logic [31:0] save_pc;                 // pc picked for mepc

  //////////////////////////////
  // read decode
  //////////////////////////////
  always_comb begin
    rdata_o = '0;  // unknown addresses read zero
    case (csr_req_i.addr)
      `CSR_ADDR_MSTATUS:  rdata_o = {31'b0, mstatus_q};
      `CSR_ADDR_MEPC:     rdata_o = mepc_q;
      `CSR_ADDR_MCAUSE:   rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      `CSR_ADDR_MHARTID:  rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      `CSR_ADDR_MIMPID:   rdata_o = `CSR_MIMPID_VAL;
      `CSR_ADDR_MESTATUS: rdata_o = {31'b0, mestatus_q};
      default: ;
    endcase
  end

  // op applied against the current read value
  always_comb begin
    we_int    = csr_req_i.access;
    wdata_int = csr_req_i.wdata;
    case (csr_req_i.op)
      csr_pkg::SET:   wdata_int = csr_req_i.wdata | rdata_o;
      csr_pkg::CLEAR: wdata_int = ~csr_req_i.wdata & rdata_o;
      csr_pkg::NONE:  we_int = 1'b0;  // read only
      default: ;
    endcase
  end

  // mepc source
  always_comb begin
    save_pc = pcs_i.pc_if;
    case (trap_ctl_i.pc_src)
      csr_pkg::PC_IF:     save_pc = pcs_i.pc_if;
      csr_pkg::PC_ID:     save_pc = pcs_i.pc_id;
      csr_pkg::PC_EX:     save_pc = pcs_i.pc_ex;
      csr_pkg::BR_TARGET: save_pc = pcs_i.branch_target;
      default: ;
    endcase
  end

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    mstatus_n  = mstatus_q;
    mestatus_n = mestatus_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    if (we_int) begin
      case (csr_req_i.addr)
        `CSR_ADDR_MSTATUS:  mstatus_n = wdata_int[0];
        `CSR_ADDR_MEPC:     mepc_n = wdata_int;
        `CSR_ADDR_MCAUSE:   mcause_n = {wdata_int[31], wdata_int[4:0]};  // same packing as read
        `CSR_ADDR_MESTATUS: mestatus_n = wdata_int[0];
        default: ;
      endcase
    end

    // trap traffic overrides csr writes
    if (trap_ctl_i.save) begin
      mestatus_n = mstatus_q;
      mstatus_n  = 1'b0;     // interrupts off in handler
      mepc_n     = save_pc;
    end
    if (trap_ctl_i.save_cause)
      mcause_n = trap_ctl_i.cause;
    if (trap_ctl_i.restore)
      mstatus_n = mestatus_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= 1'b0;
      mestatus_q <= 1'b0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mestatus_q <= mestatus_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign irq_enable_o = mstatus_q;
  assign mepc_o       = mepc_q;

  // sequencer must hand over a defined pc source with every save
  a_pc_src_known: assert property (@(posedge clk) disable iff (!rst_n)
    trap_ctl_i.save |-> !$isunknown(trap_ctl_i.pc_src));

endmodule

/* source/trap_sequencer.sv */
module trap_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                exc_req_i,     // level, held by the pipeline
  input  logic [5:0]          exc_cause_i,
  input  csr_pkg::pc_src_e    exc_pc_src_i,
  input  logic                mret_i,        // single cycle
  output csr_pkg::trap_ctl_t  trap_ctl_o,
  output logic                trap_active_o
);

  csr_pkg::trap_state_e state_q, state_n;

  //////////////////////////////
  // fsm
  //////////////////////////////
  always_comb begin
    state_n    = state_q;
    trap_ctl_o = '0;
    trap_ctl_o.cause  = exc_cause_i;   // only sampled with save_cause
    trap_ctl_o.pc_src = exc_pc_src_i;

    case (state_q)
      csr_pkg::RUN: begin
        // mret here is dropped
        if (exc_req_i) begin
          trap_ctl_o.save       = 1'b1;
          trap_ctl_o.save_cause = 1'b1;
          state_n               = csr_pkg::IN_TRAP;
        end
      end
      csr_pkg::IN_TRAP: begin
        // no nesting, further requests ignored
        if (mret_i) begin
          trap_ctl_o.restore = 1'b1;
          state_n            = csr_pkg::RUN;
        end
      end
      default: state_n = csr_pkg::RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= csr_pkg::RUN;
    end else begin
      state_q <= state_n;
    end
  end

  assign trap_active_o = (state_q == csr_pkg::IN_TRAP);

  // entry and exit pulses are exclusive
  a_save_restore_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_ctl_o.save && trap_ctl_o.restore));

endmodule

/* common/csr_pkg.sv */
package csr_pkg;

  // csr operation, matches the decoder's op field
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  // which pc lands in mepc on a trap
  typedef enum logic [1:0] {
    PC_IF     = 2'b00,
    PC_ID     = 2'b01,
    PC_EX     = 2'b10,
    BR_TARGET = 2'b11
  } pc_src_e;

  typedef enum logic {
    RUN     = 1'b0,
    IN_TRAP = 1'b1
  } trap_state_e;

  // sram-like csr port, 47 bits
  typedef struct packed {
    logic        access;
    logic [11:0] addr;
    logic [31:0] wdata;
    csr_op_e     op;
  } csr_req_t;

  // raw pipeline events for the counter bank
  typedef struct packed {
    logic id_valid;      // id stage done
    logic is_decoding;   // controller in decode
    logic ld_stall;      // load-use hazard
    logic jr_stall;      // jump register hazard
    logic imiss;         // waiting on fetch
    logic pc_set;        // pc redirected
    logic mem_load;
    logic mem_store;
    logic branch_taken;
  } perf_evt_t;

  typedef struct packed {
    logic [31:0] pc_if;
    logic [31:0] pc_id;
    logic [31:0] pc_ex;
    logic [31:0] branch_target;
  } pc_set_t;

  // sequencer to machine regs
  typedef struct packed {
    logic       save;        // mepc/mestatus capture, IE off
    logic       restore;     // IE back from mestatus
    logic       save_cause;
    logic [5:0] cause;
    pc_src_e    pc_src;
  } trap_ctl_t;

endpackage

/* common/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

//////////////////////////////
// machine csr addresses
//////////////////////////////
`define CSR_ADDR_MSTATUS   12'h300  // IE bit only
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MHARTID   12'hF10  // cluster and core id
`define CSR_ADDR_MIMPID    12'hF01
`define CSR_ADDR_MESTATUS  12'h7C0  // saved IE

//////////////////////////////
// perf counter addresses
//////////////////////////////
`define CSR_ADDR_PCER      12'h7A0  // event enable mask
`define CSR_ADDR_PCMR      12'h7A1  // mode, bit0 enable, bit1 saturate
`define CSR_ADDR_PCCR_ALL  12'h79F  // writes every counter
`define CSR_PCCR_BASE_HI   7'b0111100 // 780h..79Fh

`define CSR_N_PERF_EVT     8

`define CSR_MIMPID_VAL     32'h0000_8000

`endif
